// File: Makefile
VERILATOR  ?= verilator
FLAGS      = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_mpu
RTL_TOP    = mpu_top
FLIST      = flist.f
BUILD      = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD) $(LOG)

// File: flist.f
hdl/mpu_pkg.sv
hdl/mpu_host_decode.sv
hdl/mpu_thread_mem.sv
hdl/mpu_map_man.sv
hdl/mpu_dispatch.sv
hdl/mpu_commit.sv
hdl/mpu_top.sv
tb/mpu_checker.sv
tb/tb_mpu.sv

// File: hdl/mpu_commit.sv
// Commit tracker
// One outstanding bit per issue number and a count of open issues
// Full flag and sticky error on a commit that is not outstanding

`timescale 1ns/1ps

module mpu_commit
	import mpu_pkg::*;
(
	input	logic			clock,
	input	logic			rst_n,
	input	logic			issue_start,
	input	issue_no_t		issue_no,
	input	logic			commit_valid,
	input	issue_no_t		commit_no,
	output	logic			full,
	output	logic			commit_error
);

	logic [DEPTH_COMMIT-1:0]	pend_q;
	logic [COMMIT_CNT_W-1:0]	count_q;
	logic						hit;				// Commit of an open issue

	assign hit  = commit_valid && pend_q[commit_no];
	assign full = (count_q == COMMIT_CNT_W'(DEPTH_COMMIT));

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			pend_q       <= '0;
			count_q      <= '0;
			commit_error <= 1'b0;
		end else begin
			if (issue_start)
				pend_q[issue_no] <= 1'b1;
			if (hit)
				pend_q[commit_no] <= 1'b0;

			case ({issue_start, hit})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;		// None or both
			endcase

			if (commit_valid && !pend_q[commit_no])
				commit_error <= 1'b1;				// Stays until reset
		end
	end

endmodule

// File: hdl/mpu_dispatch.sv
// Thread dispatch
// Looks up a thread, reads its words in order and streams them
// to the array tagged with one issue number per run

`timescale 1ns/1ps

module mpu_dispatch
	import mpu_pkg::*;
(
	input	logic			clock,
	input	logic			rst_n,
	input	logic			run_valid,
	input	id_t			run_id,
	input	map_entry_t		lk_entry,
	input	instr_t			rd_instr,
	output	id_t			lk_id,
	output	logic			rd_valid,
	output	tmem_addr_t		rd_addr,
	output	logic			issue_valid,
	output	issue_t			issue,
	output	logic			issue_start,
	output	issue_no_t		issue_no,
	output	logic			sending
);

	typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_SEND} state_t;

	state_t			state;
	tmem_addr_t		addr_q;
	len_t			remain_q;					// Words left to read
	issue_no_t		next_no;
	issue_no_t		tag_q;						// Number of the running thread
	logic			rd_pend;
	logic			rd_first;
	logic			rd_last;
	logic			start_rd;
	logic			last_rd;

	assign lk_id    = run_id;
	assign start_rd = (state == ST_IDLE) && run_valid;
	assign rd_valid = start_rd || (state == ST_READ);
	assign rd_addr  = (state == ST_IDLE) ? lk_entry.base : addr_q;
	assign last_rd  = (state == ST_IDLE) ? (lk_entry.length == LEN_W'(1))
	                                     : (remain_q == LEN_W'(1));
	assign sending  = (state != ST_IDLE) || issue_valid;
	assign issue_no = issue.issue_no;

	//////////////////////////////////////////////////////////////////////
	// FSM and issue counter
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state   <= ST_IDLE;
			next_no <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (run_valid) begin
						state   <= last_rd ? ST_SEND : ST_READ;
						next_no <= next_no + 1'b1;		// Wraps with DEPTH_COMMIT
					end
				end
				ST_READ: begin
					if (last_rd)
						state <= ST_SEND;
				end
				default: state <= ST_IDLE;				// Final word leaves
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (start_rd) begin
			addr_q   <= lk_entry.base + TMEM_ADDR_W'(1);
			remain_q <= lk_entry.length - LEN_W'(1);
			tag_q    <= next_no;
		end else if (state == ST_READ) begin
			addr_q   <= addr_q + TMEM_ADDR_W'(1);
			remain_q <= remain_q - LEN_W'(1);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Issue output stage
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			rd_pend     <= 1'b0;
			issue_valid <= 1'b0;
			issue_start <= 1'b0;
		end else begin
			rd_pend     <= rd_valid;
			issue_valid <= rd_pend;
			issue_start <= rd_pend && rd_first;
		end
	end

	always_ff @(posedge clock) begin
		rd_first       <= start_rd;
		rd_last        <= rd_valid && last_rd;
		issue.instr    <= rd_instr;
		issue.issue_no <= tag_q;
		issue.last     <= rd_last;
	end

endmodule

// File: hdl/mpu_host_decode.sv
// Host command decoder
// Checks each command against the MPU state, answers the host
// and raises one internal strobe per accepted command

`timescale 1ns/1ps

module mpu_host_decode
	import mpu_pkg::*;
(
	input	logic			clock,
	input	logic			rst_n,
	input	logic			cmd_valid,
	input	host_cmd_t		cmd,
	input	map_entry_t		map,				// Entry of cmd.thread_id
	input	len_t			used_size,
	input	logic			sending,
	input	logic			full_commit,
	output	id_t			map_id,
	output	logic			resp_valid,
	output	host_resp_t		resp,
	output	logic			def_valid,
	output	id_t			def_id,
	output	len_t			def_len,
	output	logic			wr_valid,
	output	instr_t			wr_instr,
	output	logic			run_valid,
	output	id_t			run_id,
	output	logic			loading
);

	len_t				words_left;			// Words still due for the last define
	logic [LEN_W:0]		size_sum;
	resp_code_t			code;
	logic				need_resp;
	logic				accept;

	assign map_id   = cmd.thread_id;
	assign loading  = (words_left != '0);
	assign size_sum = used_size + cmd.length;
	assign accept   = cmd_valid && (code == RSP_OK);

	//////////////////////////////////////////////////////////////////////
	// Acceptance rules
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		code      = RSP_OK;
		need_resp = 1'b1;
		case (cmd.op)
			OP_DEFINE: begin
				if (map.valid || (cmd.length == '0))
					code = RSP_UNDEFINED;
				else if (loading)
					code = RSP_BUSY;					// Previous load unfinished
				else if (size_sum > SIZE_THREAD_MEM)
					code = RSP_NO_MEM;
			end
			OP_WORD: begin
				need_resp = !loading;				// Answer only a stray word
				if (!loading)
					code = RSP_BAD_WORD;
			end
			OP_RUN: begin
				if (!map.valid)
					code = RSP_UNDEFINED;
				else if (sending || run_valid || loading)
					code = RSP_BUSY;
				else if (full_commit)
					code = RSP_COMMIT_FULL;
			end
			default: code = RSP_UNDEFINED;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			resp_valid <= 1'b0;
			def_valid  <= 1'b0;
			wr_valid   <= 1'b0;
			run_valid  <= 1'b0;
			words_left <= '0;
		end else begin
			resp_valid <= cmd_valid && need_resp;
			def_valid  <= accept && (cmd.op == OP_DEFINE);
			wr_valid   <= accept && (cmd.op == OP_WORD);
			run_valid  <= accept && (cmd.op == OP_RUN);
			if (accept && (cmd.op == OP_DEFINE))
				words_left <= cmd.length;
			else if (accept && (cmd.op == OP_WORD))
				words_left <= words_left - 1'b1;
		end
	end

	// Payload follows the command
	always_ff @(posedge clock) begin
		if (cmd_valid) begin
			resp.code      <= code;
			resp.thread_id <= cmd.thread_id;
			def_id         <= cmd.thread_id;
			def_len        <= cmd.length;
			wr_instr       <= cmd.instr;
			run_id         <= cmd.thread_id;
		end
	end

endmodule

// File: hdl/mpu_map_man.sv
// Thread map manager
// Per-thread base, length and valid, plus the used-size counter
// Two combinational lookups, one for decode and one for dispatch

`timescale 1ns/1ps

module mpu_map_man
	import mpu_pkg::*;
(
	input	logic			clock,
	input	logic			rst_n,
	input	logic			def_valid,
	input	id_t			def_id,
	input	len_t			def_len,
	input	id_t			map_id,
	input	id_t			lk_id,
	output	map_entry_t		map,
	output	map_entry_t		lk_entry,
	output	len_t			used_size
);

	logic [NUM_THREADS-1:0]	valid_q;
	tmem_addr_t				base_q [NUM_THREADS];
	len_t					len_q  [NUM_THREADS];

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			valid_q   <= '0;
			used_size <= '0;
		end else if (def_valid) begin
			valid_q[def_id] <= 1'b1;
			used_size       <= used_size + def_len;	// Next thread starts here
		end
	end

	always_ff @(posedge clock) begin
		if (def_valid) begin
			base_q[def_id] <= used_size[TMEM_ADDR_W-1:0];
			len_q[def_id]  <= def_len;
		end
	end

	// Lookup ports
	assign map      = '{valid: valid_q[map_id], base: base_q[map_id], length: len_q[map_id]};
	assign lk_entry = '{valid: valid_q[lk_id], base: base_q[lk_id], length: len_q[lk_id]};

endmodule

// File: hdl/mpu_pkg.sv
// Shared definitions of the MPU
// Sizes of thread storage, map table and commit window
// Host command and response formats
// Issue word sent to the array and the status word

package mpu_pkg;

	//////////////////////////////////////////////////////////////////////
	// Sizes
	//////////////////////////////////////////////////////////////////////
	localparam int NUM_THREADS     = 8;
	localparam int THREAD_ID_W     = 3;
	localparam int SIZE_THREAD_MEM = 64;			// Instruction words
	localparam int TMEM_ADDR_W     = 6;
	localparam int LEN_W           = 7;				// Holds 1 to 64
	localparam int DEPTH_COMMIT    = 4;				// Max outstanding issues
	localparam int ISSUE_NO_W      = 2;				// Wraps modulo DEPTH_COMMIT
	localparam int COMMIT_CNT_W    = 3;				// Counts 0 to DEPTH_COMMIT
	localparam int INSTR_W         = 32;

	//////////////////////////////////////////////////////////////////////
	// Basic types
	//////////////////////////////////////////////////////////////////////
	typedef logic [INSTR_W-1:0]     instr_t;
	typedef logic [THREAD_ID_W-1:0] id_t;
	typedef logic [ISSUE_NO_W-1:0]  issue_no_t;
	typedef logic [TMEM_ADDR_W-1:0] tmem_addr_t;
	typedef logic [LEN_W-1:0]       len_t;

	typedef enum logic [1:0] {
		OP_DEFINE,						// Declare id and length
		OP_WORD,						// Append one instruction
		OP_RUN							// Start a thread
	} host_op_t;

	typedef enum logic [2:0] {
		RSP_OK,
		RSP_NO_MEM,
		RSP_UNDEFINED,
		RSP_BUSY,
		RSP_COMMIT_FULL,
		RSP_BAD_WORD
	} resp_code_t;

	//////////////////////////////////////////////////////////////////////
	// Structs
	//////////////////////////////////////////////////////////////////////
	typedef struct packed {
		host_op_t op;
		id_t      thread_id;
		len_t     length;
		instr_t   instr;
	} host_cmd_t;

	typedef struct packed {
		resp_code_t code;
		id_t        thread_id;
	} host_resp_t;

	typedef struct packed {
		logic       valid;
		tmem_addr_t base;
		len_t       length;
	} map_entry_t;

	typedef struct packed {
		instr_t    instr;
		issue_no_t issue_no;
		logic      last;						// Final word of the thread
	} issue_t;

	typedef struct packed {
		logic loading;
		logic sending;
		logic full_commit;
		logic commit_error;					// Sticky
		len_t used_size;
	} mpu_stat_t;

endpackage

// File: hdl/mpu_thread_mem.sv
// Thread instruction storage
// Append-only write at an internal pointer, registered read port

`timescale 1ns/1ps

module mpu_thread_mem
	import mpu_pkg::*;
(
	input	logic			clock,
	input	logic			rst_n,
	input	logic			wr_valid,
	input	instr_t			wr_instr,
	input	logic			rd_valid,
	input	tmem_addr_t		rd_addr,
	output	instr_t			rd_instr
);

	instr_t			mem [SIZE_THREAD_MEM];
	tmem_addr_t		wr_ptr;					// Tracks used size of the map table

	//////////////////////////////////////////////////////////////////////
	// Write pointer
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (!rst_n)
			wr_ptr <= '0;
		else if (wr_valid)
			wr_ptr <= wr_ptr + 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// Storage array
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (wr_valid)
			mem[wr_ptr] <= wr_instr;
		if (rd_valid)
			rd_instr <= mem[rd_addr];			// Data one cycle after request
	end

endmodule

// File: hdl/mpu_top.sv
// MPU top level
// Host decode, thread storage, map manager, dispatch and commit
// wired to the host and array ports, plus the status word

`timescale 1ns/1ps

module mpu_top
	import mpu_pkg::*;
(
	input	logic			clock,
	input	logic			rst_n,
	input	logic			cmd_valid,
	input	host_cmd_t		cmd,
	input	logic			commit_valid,
	input	issue_no_t		commit_no,
	output	logic			resp_valid,
	output	host_resp_t		resp,
	output	logic			issue_valid,
	output	issue_t			issue,
	output	mpu_stat_t		status
);

	id_t			map_id, lk_id, def_id, run_id;
	map_entry_t		map, lk_entry;
	len_t			used_size, def_len;
	logic			def_valid, wr_valid, run_valid, rd_valid;
	logic			loading, sending, full_commit, commit_error, issue_start;
	instr_t			wr_instr, rd_instr;
	tmem_addr_t		rd_addr;
	issue_no_t		issue_no;

	assign status = '{loading: loading, sending: sending, full_commit: full_commit,
	                  commit_error: commit_error, used_size: used_size};

	mpu_host_decode u_decode (
		.clock(clock), .rst_n(rst_n), .cmd_valid(cmd_valid), .cmd(cmd),
		.map(map), .used_size(used_size), .sending(sending), .full_commit(full_commit),
		.map_id(map_id), .resp_valid(resp_valid), .resp(resp),
		.def_valid(def_valid), .def_id(def_id), .def_len(def_len),
		.wr_valid(wr_valid), .wr_instr(wr_instr), .run_valid(run_valid),
		.run_id(run_id), .loading(loading)
	);

	mpu_thread_mem u_thread_mem (
		.clock(clock), .rst_n(rst_n), .wr_valid(wr_valid), .wr_instr(wr_instr),
		.rd_valid(rd_valid), .rd_addr(rd_addr), .rd_instr(rd_instr)
	);

	mpu_map_man u_map_man (
		.clock(clock), .rst_n(rst_n), .def_valid(def_valid), .def_id(def_id),
		.def_len(def_len), .map_id(map_id), .lk_id(lk_id), .map(map),
		.lk_entry(lk_entry), .used_size(used_size)
	);

	mpu_dispatch u_dispatch (
		.clock(clock), .rst_n(rst_n), .run_valid(run_valid), .run_id(run_id),
		.lk_entry(lk_entry), .rd_instr(rd_instr), .lk_id(lk_id), .rd_valid(rd_valid),
		.rd_addr(rd_addr), .issue_valid(issue_valid), .issue(issue),
		.issue_start(issue_start), .issue_no(issue_no), .sending(sending)
	);

	mpu_commit u_commit (
		.clock(clock), .rst_n(rst_n), .issue_start(issue_start), .issue_no(issue_no),
		.commit_valid(commit_valid), .commit_no(commit_no), .full(full_commit),
		.commit_error(commit_error)
	);

endmodule

// File: tb/mpu_checker.sv
// Testbench checker of the MPU
// Queues of expected responses and issue words, compared in arrival order
// Delay of the first issue word after an accepted RUN
// Status probes, missing items at the end of a test, error tally

`timescale 1ns/1ps

module mpu_checker
	import mpu_pkg::*;
(
	input	logic			clock,
	input	logic			rst_n,
	input	logic			resp_valid,
	input	host_resp_t		resp,
	input	logic			issue_valid,
	input	issue_t			issue,
	input	mpu_stat_t		status,
	input	logic			exp_resp_valid,		// Push one expected response
	input	host_resp_t		exp_resp,
	input	logic			exp_issue_valid,	// Push one expected issue word
	input	issue_t			exp_issue,
	input	logic			run_mark,			// Accepted RUN sampled on this edge
	input	logic			stat_chk,
	input	mpu_stat_t		exp_stat,
	input	logic			test_end,
	output	int				pending,
	output	int				errors,
	output	int				checks
);

	host_resp_t		resp_q [$];
	issue_t			issue_q [$];
	host_resp_t		r;
	issue_t			w;
	int				cyc;
	int				mark_cyc;
	logic			mark_pend;

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic report_failure(input string msg);
		errors++;
		$display("%0t: %s", $time, msg);
	endtask

	initial begin
		errors    = 0;
		checks    = 0;
		pending   = 0;
		cyc       = 0;
		mark_cyc  = 0;
		mark_pend = 1'b0;
	end

	//////////////////////////////////////////////////////////////////////
	// Compare on every rising edge
	//////////////////////////////////////////////////////////////////////
	always @(posedge clock) begin
		cyc++;
		if (rst_n) begin
			if (exp_resp_valid)
				resp_q.push_back(exp_resp);
			if (exp_issue_valid)
				issue_q.push_back(exp_issue);
			if (run_mark) begin
				mark_cyc  = cyc;
				mark_pend = 1'b1;
			end

			if (resp_valid) begin
				if (resp_q.size() == 0) begin
					report_failure("a response arrived while none was expected");
				end else begin
					r = resp_q.pop_front();
					check_value("resp.code", resp.code, r.code);
					check_value("resp.thread_id", resp.thread_id, r.thread_id);
				end
			end

			if (issue_valid) begin
				if (mark_pend && (cyc - mark_cyc != 3))
					report_failure($sformatf("first issue word came %0d cycles after RUN, not 3",
						cyc - mark_cyc));
				mark_pend = 1'b0;
				if (issue_q.size() == 0) begin
					report_failure("an issue word arrived while none was expected");
				end else begin
					w = issue_q.pop_front();
					check_value("issue.instr", issue.instr, w.instr);
					check_value("issue.issue_no", issue.issue_no, w.issue_no);
					check_value("issue.last", issue.last, w.last);
				end
			end

			if (stat_chk)
				check_value("status", status, exp_stat);

			if (test_end && (resp_q.size() != 0 || issue_q.size() != 0)) begin
				report_failure($sformatf("%0d responses and %0d issue words never arrived",
					resp_q.size(), issue_q.size()));
				resp_q.delete();
				issue_q.delete();
			end
			pending = resp_q.size() + issue_q.size();
		end
	end

endmodule

// File: tb/tb_mpu.sv
// Testbench top of the MPU
// Clock, reset, xorshift source, host commands and array commits
// Reference model of map table, storage, issue counter and open set
// Watchdog on the whole run

`timescale 1ns/1ps

module tb_mpu
	import mpu_pkg::*;
();

	localparam int MAX_LEN    = 16;
	localparam int CMD_BUDGET = 3 * (1 + MAX_LEN) + 40;	// Loads, then runs, commits, probes

	logic			clock;
	logic			rst_n;
	logic			cmd_valid;
	host_cmd_t		cmd;
	logic			commit_valid;
	issue_no_t		commit_no;
	logic			resp_valid;
	host_resp_t		resp;
	logic			issue_valid;
	issue_t			issue;
	mpu_stat_t		status;
	logic			exp_resp_valid, exp_issue_valid, run_mark, stat_chk, test_end;
	host_resp_t		exp_resp;
	issue_t			exp_issue;
	mpu_stat_t		exp_stat;
	int				pending, errors, checks, err_mark;

	//////////////////////////////////////////////////////////////////////
	// Reference model state
	//////////////////////////////////////////////////////////////////////
	logic [31:0]				rng;
	logic						ref_valid [NUM_THREADS];
	int							ref_base [NUM_THREADS];
	int							ref_len [NUM_THREADS];
	instr_t						ref_mem [SIZE_THREAD_MEM];
	int							ref_used;
	logic [DEPTH_COMMIT-1:0]	ref_open;				// Outstanding issue numbers
	int							ref_count;
	issue_no_t					ref_next;
	logic						ref_err;
	logic						ref_sending;
	issue_no_t					first_no;

	mpu_top uut (
		.clock, .rst_n, .cmd_valid, .cmd, .commit_valid, .commit_no,
		.resp_valid, .resp, .issue_valid, .issue, .status
	);

	mpu_checker chk (
		.clock, .rst_n, .resp_valid, .resp, .issue_valid, .issue, .status,
		.exp_resp_valid, .exp_resp, .exp_issue_valid, .exp_issue, .run_mark,
		.stat_chk, .exp_stat, .test_end, .pending, .errors, .checks
	);

	always #5 clock = ~clock;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic resp_code_t define_code(input id_t id, input int len);
		if (ref_valid[id] || len == 0)
			return RSP_UNDEFINED;
		if (ref_used + len > SIZE_THREAD_MEM)
			return RSP_NO_MEM;
		return RSP_OK;
	endfunction

	function automatic resp_code_t run_code(input id_t id);
		if (!ref_valid[id])
			return RSP_UNDEFINED;
		if (ref_sending)
			return RSP_BUSY;
		if (ref_count == DEPTH_COMMIT)
			return RSP_COMMIT_FULL;
		return RSP_OK;
	endfunction

	// Load and stream flags come from the caller
	function automatic mpu_stat_t ref_status(input logic loading, input logic sending);
		return '{loading: loading, sending: sending, full_commit: (ref_count == DEPTH_COMMIT),
		         commit_error: ref_err, used_size: len_t'(ref_used)};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Drivers 1 ns after the rising edge
	//////////////////////////////////////////////////////////////////////
	task automatic tick();
		@(posedge clock);
		#1;
		cmd_valid       = 1'b0;
		commit_valid    = 1'b0;
		exp_resp_valid  = 1'b0;
		exp_issue_valid = 1'b0;
		run_mark        = 1'b0;
		stat_chk        = 1'b0;
		test_end        = 1'b0;
	endtask

	task automatic send_cmd(input host_op_t op, input id_t id, input int len,
			input instr_t instr, input logic want_resp, input resp_code_t code);
		tick();
		cmd_valid      = 1'b1;
		cmd            = '{op: op, thread_id: id, length: len_t'(len), instr: instr};
		exp_resp_valid = want_resp;
		exp_resp       = '{code: code, thread_id: id};
	endtask

	task automatic probe_status(input logic loading, input logic sending);
		tick();
		stat_chk = 1'b1;
		exp_stat = ref_status(loading, sending);
	endtask

	task automatic check_status();
		probe_status(1'b0, 1'b0);
	endtask

	task automatic define_thread(input id_t id, input int len);
		resp_code_t code;
		code = define_code(id, len);
		send_cmd(OP_DEFINE, id, len, '0, 1'b1, code);
		if (code == RSP_OK) begin
			ref_valid[id] = 1'b1;
			ref_base[id]  = ref_used;
			ref_len[id]   = len;
			ref_used     += len;						// Storage is append-only
			for (int k = 0; k < len; k++) begin
				rng = xorshift(rng);
				ref_mem[ref_base[id] + k] = rng;
				send_cmd(OP_WORD, id, 0, rng, 1'b0, RSP_OK);
				if (k == 0 && len > 1)
					probe_status(1'b1, 1'b0);			// Words still due
			end
		end
	endtask

	task automatic run_thread(input id_t id);
		resp_code_t code;
		code = run_code(id);
		if (code == RSP_OK) begin
			for (int k = 0; k < ref_len[id]; k++) begin
				tick();
				exp_issue_valid = 1'b1;
				exp_issue       = '{instr: ref_mem[ref_base[id] + k], issue_no: ref_next,
				                    last: (k == ref_len[id] - 1)};
			end
		end
		send_cmd(OP_RUN, id, 0, '0, 1'b1, code);
		if (code == RSP_OK) begin
			run_mark           = 1'b1;
			ref_open[ref_next] = 1'b1;
			ref_count++;
			ref_next++;							// Wraps modulo DEPTH_COMMIT
			ref_sending = 1'b1;
		end
	endtask

	task automatic wait_idle();
		tick();
		while (pending != 0 || status.sending)
			tick();
		ref_sending = 1'b0;
	endtask

	task automatic commit_issue(input issue_no_t no);
		tick();
		commit_valid = 1'b1;
		commit_no    = no;
		if (ref_open[no]) begin
			ref_open[no] = 1'b0;
			ref_count--;
		end else begin
			ref_err = 1'b1;
		end
	endtask

	task automatic end_test(input string name);
		tick();
		test_end = 1'b1;
		tick();
		$display("Test %-13s done, %0d errors", name, errors - err_mark);
		err_mark = errors;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////
	initial begin
		clock           = 1'b0;
		rst_n           = 1'b0;
		cmd_valid       = 1'b0;
		cmd             = '0;
		commit_valid    = 1'b0;
		commit_no       = '0;
		exp_resp_valid  = 1'b0;
		exp_resp        = '0;
		exp_issue_valid = 1'b0;
		exp_issue       = '0;
		run_mark        = 1'b0;
		stat_chk        = 1'b0;
		exp_stat        = '0;
		test_end        = 1'b0;
		err_mark        = 0;
		rng             = 32'had3f9248;
		for (int i = 0; i < NUM_THREADS; i++)
			ref_valid[i] = 1'b0;
		ref_used    = 0;
		ref_open    = '0;
		ref_count   = 0;
		ref_next    = '0;
		ref_err     = 1'b0;
		ref_sending = 1'b0;
		repeat (16) @(posedge clock);
		#1 rst_n = 1'b1;

		check_status();
		end_test("reset");

		for (int i = 0; i < 3; i++) begin
			rng = xorshift(rng);
			define_thread(id_t'(i), 4 + int'(rng % (MAX_LEN - 3)));
		end
		for (int i = 0; i < 3; i++) begin
			run_thread(id_t'(i));
			wait_idle();
		end
		for (int i = 0; i < 3; i++)
			commit_issue(issue_no_t'(i));
		check_status();
		end_test("load_and_run");

		for (int i = 0; i < 5; i++) begin
			run_thread(id_t'(i % 3));
			wait_idle();
			commit_issue(ref_next - 1'b1);
		end
		check_status();
		end_test("issue_wrap");

		run_thread(3'd5);								// Never defined
		define_thread(3'd6, SIZE_THREAD_MEM - ref_used + 1);
		define_thread(3'd7, 0);
		send_cmd(OP_WORD, 3'd0, 0, '0, 1'b1, RSP_BAD_WORD);
		check_status();
		end_test("rejects");

		run_thread(3'd0);
		tick();
		run_thread(3'd1);								// Lands while thread 0 streams
		probe_status(1'b0, 1'b1);
		wait_idle();
		commit_issue(ref_next - 1'b1);
		check_status();
		end_test("busy");

		first_no = ref_next;
		for (int i = 0; i < DEPTH_COMMIT; i++) begin
			run_thread(3'd2);
			wait_idle();
		end
		check_status();
		run_thread(3'd2);
		commit_issue(first_no);
		check_status();
		run_thread(3'd2);
		wait_idle();
		for (int i = 0; i < DEPTH_COMMIT; i++)
			if (ref_open[i])
				commit_issue(issue_no_t'(i));
		check_status();
		end_test("commit_full");

		commit_issue(ref_next);						// Nothing is outstanding
		check_status();
		repeat (4) tick();
		check_status();
		end_test("commit_error");

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (CMD_BUDGET * 80) @(posedge clock);
		$display("Watchdog expired after %0d cycles, the run did not finish", CMD_BUDGET * 80);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule
